//--- nn_pkg.sv
package nn_pkg;

    // Datapath sizing
    localparam int DATA_W    = 32;
    localparam int SHAMT_W   = 5;   // Shift amount bits taken from a shift parameter
    localparam int PARAM_NUM = 10;  // Weights, biases and shifts
    localparam int PADDR_W   = 4;   // APB word address

    // Largest positive value, driven out on overflow
    localparam logic signed [DATA_W-1:0] SAT_POS = {1'b0, {(DATA_W-1){1'b1}}};

    // APB word address of each network parameter
    typedef enum logic [PADDR_W-1:0] {
        PI_SHIFT1 = 4'd0,   // Pre-shift of input_1
        PI_SHIFT2 = 4'd1,   // Pre-shift of input_2
        PI_W1     = 4'd2,
        PI_B1     = 4'd3,
        PI_W2     = 4'd4,
        PI_B2     = 4'd5,
        PI_W3     = 4'd6,
        PI_W4     = 4'd7,
        PI_B3     = 4'd8,
        PI_SHIFT3 = 4'd9    // Post-shift of the result
    } param_idx_t;

    // Sequencer states
    // Encodings are reported as-is on the stage outputs
    typedef enum logic [2:0] {
        ST_IDLE = 3'd2,     // Waiting for enable
        ST_PRE  = 3'd3,     // Input shifts
        ST_IN   = 3'd4,     // Parallel MACs
        ST_OUT  = 3'd5,     // Serial MACs, two cycles
        ST_POST = 3'd6      // Output shift
    } nn_state_t;

    localparam logic [2:0] STAGE_NONE = 3'd7;  // No stage recorded

    // Shift unit opcodes
    typedef enum logic {
        OP_ASR = 1'b0,      // Arithmetic right
        OP_ASL = 1'b1       // Arithmetic left, overflow checked
    } alu_op_t;

endpackage

//--- nn_alu.sv
`timescale 1ns/1ps

module nn_alu import nn_pkg::*; (
    input  logic signed [DATA_W-1:0] op1,
    input  logic [SHAMT_W-1:0]       shamt,
    input  alu_op_t                  op,
    output logic signed [DATA_W-1:0] result,
    output logic                     ovf,
    output logic                     zero
);

    logic signed [DATA_W-1:0] asr_res;   // Right shift, sign filled
    logic signed [DATA_W-1:0] asl_res;   // Left shift, may drop bits
    logic signed [DATA_W-1:0] asl_back;  // Left result undone

    assign asr_res  = op1 >>> shamt;
    assign asl_res  = op1 <<< shamt;
    assign asl_back = asl_res >>> shamt;  // Differs from op1 when bits were lost

    always_comb begin
        result = asr_res;
        ovf    = 1'b0;
        case (op)
            OP_ASR: begin
                result = asr_res;         // Cannot overflow
                ovf    = 1'b0;
            end
            OP_ASL: begin
                result = asl_res;
                ovf    = (asl_back != op1);
            end
            default: begin
                result = asr_res;
                ovf    = 1'b0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- nn_mac.sv
`timescale 1ns/1ps

module nn_mac import nn_pkg::*; (
    input  logic signed [DATA_W-1:0] op1,      // Multiplicand
    input  logic signed [DATA_W-1:0] op2,      // Multiplier
    input  logic signed [DATA_W-1:0] op3,      // Addend
    output logic signed [DATA_W-1:0] result,
    output logic                     ovf_mul,
    output logic                     ovf_add,
    output logic                     zero_mul,
    output logic                     zero_add
);

    logic signed [2*DATA_W-1:0] prod;     // Full-width product
    logic signed [DATA_W-1:0]   prod_lo;  // Truncated product

    assign prod    = op1 * op2;
    assign prod_lo = prod[DATA_W-1:0];

    // Fits only if the upper half is a sign extension of bit DATA_W-1
    assign ovf_mul = (prod[2*DATA_W-1:DATA_W-1] != {(DATA_W+1){prod[DATA_W-1]}});

    assign result = prod_lo + op3;

    // Same-sign operands with a flipped result sign
    assign ovf_add = (prod_lo[DATA_W-1] == op3[DATA_W-1]) &&
                     (result[DATA_W-1] != op3[DATA_W-1]);

    assign zero_mul = (prod_lo == '0);
    assign zero_add = (result == '0);

endmodule

//--- nn_param_regs.sv
`timescale 1ns/1ps

module nn_param_regs import nn_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [PADDR_W-1:0]       paddr,
    input  logic [DATA_W-1:0]        pwdata,
    input  logic                     busy,      // Sequencer running
    output logic [DATA_W-1:0]        prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic [SHAMT_W-1:0]       shift1,
    output logic [SHAMT_W-1:0]       shift2,
    output logic [SHAMT_W-1:0]       shift3,
    output logic signed [DATA_W-1:0] w1,
    output logic signed [DATA_W-1:0] b1,
    output logic signed [DATA_W-1:0] w2,
    output logic signed [DATA_W-1:0] b2,
    output logic signed [DATA_W-1:0] w3,
    output logic signed [DATA_W-1:0] w4,
    output logic signed [DATA_W-1:0] b3
);

    logic [DATA_W-1:0] params [PARAM_NUM];  // Parameter store
    logic              addr_ok;             // Address maps to a parameter
    logic              access;              // APB transfer completes this cycle

    assign addr_ok = (paddr < PADDR_W'(PARAM_NUM));
    assign pready  = ~busy;                 // Stall the access phase during a run
    assign access  = psel & penable & pready;
    assign pslverr = access & ~addr_ok;     // Out-of-range word

    // Read mux, zero outside the store
    assign prdata = addr_ok ? params[paddr] : '0;

    // Write on the completing edge only
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < PARAM_NUM; i++) begin
                params[i] <= '0;
            end
        end else if (access && pwrite && addr_ok) begin
            params[paddr] <= pwdata;
        end
    end

    // Shift amounts, low bits only
    assign shift1 = params[PI_SHIFT1][SHAMT_W-1:0];
    assign shift2 = params[PI_SHIFT2][SHAMT_W-1:0];
    assign shift3 = params[PI_SHIFT3][SHAMT_W-1:0];

    // Weights and biases as signed words
    assign w1 = $signed(params[PI_W1]);
    assign b1 = $signed(params[PI_B1]);
    assign w2 = $signed(params[PI_W2]);
    assign b2 = $signed(params[PI_B2]);
    assign w3 = $signed(params[PI_W3]);
    assign w4 = $signed(params[PI_W4]);
    assign b3 = $signed(params[PI_B3]);

endmodule

//--- nn_seq.sv
`timescale 1ns/1ps

module nn_seq import nn_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     enable,      // Sampled in idle
    input  logic signed [DATA_W-1:0] input_1,
    input  logic signed [DATA_W-1:0] input_2,
    input  logic [SHAMT_W-1:0]       shift1,
    input  logic [SHAMT_W-1:0]       shift2,
    input  logic [SHAMT_W-1:0]       shift3,
    input  logic signed [DATA_W-1:0] w1,
    input  logic signed [DATA_W-1:0] b1,
    input  logic signed [DATA_W-1:0] w2,
    input  logic signed [DATA_W-1:0] b2,
    input  logic signed [DATA_W-1:0] w3,
    input  logic signed [DATA_W-1:0] w4,
    input  logic signed [DATA_W-1:0] b3,
    output logic signed [DATA_W-1:0] final_output,
    output logic                     total_ovf,   // Sticky
    output logic                     total_zero,  // Sticky
    output logic [2:0]               ovf_stage,   // First overflowing stage
    output logic [2:0]               zero_stage,  // First stage giving zero
    output logic                     busy
);

    nn_state_t state;
    nn_state_t next_state;
    logic      out_step;                  // Output layer step, 0 then 1

    // Intermediate registers
    logic signed [DATA_W-1:0] inter_1;
    logic signed [DATA_W-1:0] inter_2;
    logic signed [DATA_W-1:0] inter_3;
    logic signed [DATA_W-1:0] inter_4;
    logic signed [DATA_W-1:0] temp;       // First output-layer MAC
    logic signed [DATA_W-1:0] inter_5;

    // Unit operands and results
    logic signed [DATA_W-1:0] alu1_op1;
    logic [SHAMT_W-1:0]       alu1_sh;
    alu_op_t                  alu1_op;
    logic signed [DATA_W-1:0] alu1_res;
    logic signed [DATA_W-1:0] alu2_res;
    logic                     alu1_ovf;
    logic                     alu1_zero;
    logic                     alu2_ovf;
    logic                     alu2_zero;
    logic signed [DATA_W-1:0] mac1_op1;
    logic signed [DATA_W-1:0] mac1_op2;
    logic signed [DATA_W-1:0] mac1_op3;
    logic signed [DATA_W-1:0] mac2_op1;
    logic signed [DATA_W-1:0] mac2_op2;
    logic signed [DATA_W-1:0] mac2_op3;
    logic signed [DATA_W-1:0] mac1_res;
    logic signed [DATA_W-1:0] mac2_res;
    logic                     mac1_ovf_mul;
    logic                     mac1_ovf_add;
    logic                     mac1_zero_mul;
    logic                     mac1_zero_add;
    logic                     mac2_ovf_mul;
    logic                     mac2_ovf_add;
    logic                     mac2_zero_mul;
    logic                     mac2_zero_add;

    logic stage_ovf;                      // Current stage overflowed
    logic stage_zero;                     // Current stage gave a zero

    // ALU 1 serves pre and post, ALU 2 pre only
    nn_alu u_alu_1 (
        .op1(alu1_op1), .shamt(alu1_sh), .op(alu1_op),
        .result(alu1_res), .ovf(alu1_ovf), .zero(alu1_zero)
    );
    nn_alu u_alu_2 (
        .op1(input_2), .shamt(shift2), .op(OP_ASR),
        .result(alu2_res), .ovf(alu2_ovf), .zero(alu2_zero)
    );

    nn_mac u_mac_1 (
        .op1(mac1_op1), .op2(mac1_op2), .op3(mac1_op3), .result(mac1_res),
        .ovf_mul(mac1_ovf_mul), .ovf_add(mac1_ovf_add),
        .zero_mul(mac1_zero_mul), .zero_add(mac1_zero_add)
    );
    nn_mac u_mac_2 (
        .op1(mac2_op1), .op2(mac2_op2), .op3(mac2_op3), .result(mac2_res),
        .ovf_mul(mac2_ovf_mul), .ovf_add(mac2_ovf_add),
        .zero_mul(mac2_zero_mul), .zero_add(mac2_zero_add)
    );

    // Operand steering by state
    always_comb begin
        alu1_op1 = input_1;               // Pre-processing by default
        alu1_sh  = shift1;
        alu1_op  = OP_ASR;
        mac1_op1 = inter_1;               // Input layer by default
        mac1_op2 = w1;
        mac1_op3 = b1;
        mac2_op1 = inter_2;
        mac2_op2 = w2;
        mac2_op3 = b2;
        case (state)
            ST_OUT: begin
                mac1_op1 = inter_3;       // Step 0
                mac1_op2 = w3;
                mac1_op3 = b3;
                mac2_op1 = inter_4;       // Step 1, chained on temp
                mac2_op2 = w4;
                mac2_op3 = temp;
            end
            ST_POST: begin
                alu1_op1 = inter_5;
                alu1_sh  = shift3;
                alu1_op  = OP_ASL;
            end
            default: ;
        endcase
    end

    // Flags raised by the active units
    always_comb begin
        stage_ovf  = 1'b0;
        stage_zero = 1'b0;
        case (state)
            ST_PRE: begin
                stage_ovf  = alu1_ovf | alu2_ovf;
                stage_zero = alu1_zero | alu2_zero;
            end
            ST_IN: begin
                stage_ovf  = mac1_ovf_mul | mac1_ovf_add | mac2_ovf_mul | mac2_ovf_add;
                stage_zero = mac1_zero_mul | mac1_zero_add | mac2_zero_mul | mac2_zero_add;
            end
            ST_OUT: begin
                if (out_step) begin
                    stage_ovf  = mac2_ovf_mul | mac2_ovf_add;
                    stage_zero = mac2_zero_mul | mac2_zero_add;
                end else begin
                    stage_ovf  = mac1_ovf_mul | mac1_ovf_add;
                    stage_zero = mac1_zero_mul | mac1_zero_add;
                end
            end
            ST_POST: begin
                stage_ovf  = alu1_ovf;
                stage_zero = alu1_zero;
            end
            default: ;
        endcase
    end

    // Next state, overflow aborts to idle
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: if (enable) next_state = ST_PRE;
            ST_PRE:  next_state = ST_IN;
            ST_IN:   next_state = ST_OUT;
            ST_OUT:  if (out_step) next_state = ST_POST;
            ST_POST: next_state = ST_IDLE;
            default: next_state = ST_IDLE;
        endcase
        if (stage_ovf) begin
            next_state = ST_IDLE;
        end
    end

    // State, output register and sticky flags
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state        <= ST_IDLE;
            out_step     <= 1'b0;
            final_output <= '0;
            total_ovf    <= 1'b0;
            total_zero   <= 1'b0;
            ovf_stage    <= STAGE_NONE;
            zero_stage   <= STAGE_NONE;
        end else begin
            state    <= next_state;
            out_step <= (state == ST_OUT) && !out_step && !stage_ovf;
            if (stage_ovf) begin
                final_output <= SAT_POS;      // Saturate on any overflow
            end else if (state == ST_POST) begin
                final_output <= alu1_res;
            end
            if (state == ST_IDLE && enable) begin
                total_ovf  <= 1'b0;           // New run
                total_zero <= 1'b0;
                ovf_stage  <= STAGE_NONE;
                zero_stage <= STAGE_NONE;
            end else begin
                if (stage_zero) begin
                    total_zero <= 1'b1;
                    if (!total_zero) zero_stage <= state;  // First one only
                end
                if (stage_ovf) begin
                    total_ovf <= 1'b1;
                    if (!total_ovf) ovf_stage <= state;
                end
            end
        end
    end

    // Intermediate registers, loaded by the active stage
    always_ff @(posedge clk) begin
        case (state)
            ST_PRE: begin
                inter_1 <= alu1_res;
                inter_2 <= alu2_res;
            end
            ST_IN: begin
                inter_3 <= mac1_res;
                inter_4 <= mac2_res;
            end
            ST_OUT: begin
                if (out_step) inter_5 <= mac2_res;
                else          temp    <= mac1_res;
            end
            default: ;
        endcase
    end

    assign busy = (state != ST_IDLE);

endmodule

//--- nn_top.sv
`timescale 1ns/1ps

module nn_top import nn_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    // APB slave
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [PADDR_W-1:0]       paddr,
    input  logic [DATA_W-1:0]        pwdata,
    output logic [DATA_W-1:0]        prdata,
    output logic                     pready,
    output logic                     pslverr,
    // Compute side
    input  logic                     enable,
    input  logic signed [DATA_W-1:0] input_1,
    input  logic signed [DATA_W-1:0] input_2,
    output logic signed [DATA_W-1:0] final_output,
    output logic                     total_ovf,
    output logic                     total_zero,
    output logic [2:0]               ovf_stage,
    output logic [2:0]               zero_stage,
    output logic                     busy
);

    // Parameter store to sequencer
    logic [SHAMT_W-1:0]       shift1;
    logic [SHAMT_W-1:0]       shift2;
    logic [SHAMT_W-1:0]       shift3;
    logic signed [DATA_W-1:0] w1;
    logic signed [DATA_W-1:0] b1;
    logic signed [DATA_W-1:0] w2;
    logic signed [DATA_W-1:0] b2;
    logic signed [DATA_W-1:0] w3;
    logic signed [DATA_W-1:0] w4;
    logic signed [DATA_W-1:0] b3;

    nn_param_regs u_regs (
        .clk(clk), .resetn(resetn),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .busy(busy),                      // Back-pressure during a run
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .shift1(shift1), .shift2(shift2), .shift3(shift3),
        .w1(w1), .b1(b1), .w2(w2), .b2(b2),
        .w3(w3), .w4(w4), .b3(b3)
    );

    nn_seq u_seq (
        .clk(clk), .resetn(resetn),
        .enable(enable), .input_1(input_1), .input_2(input_2),
        .shift1(shift1), .shift2(shift2), .shift3(shift3),
        .w1(w1), .b1(b1), .w2(w2), .b2(b2),
        .w3(w3), .w4(w4), .b3(b3),
        .final_output(final_output),
        .total_ovf(total_ovf), .total_zero(total_zero),
        .ovf_stage(ovf_stage), .zero_stage(zero_stage),
        .busy(busy)
    );

endmodule

//--- tb_nn.sv
`timescale 1ns/1ps

module tb_nn import nn_pkg::*; ();

    localparam int APB_TIMEOUT = 50;    // Cycles an APB access may stall
    localparam int RUN_TIMEOUT = 50;    // Cycles a run may stay busy

    logic                     clk;
    logic                     resetn;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [PADDR_W-1:0]       paddr;
    logic [DATA_W-1:0]        pwdata;
    logic [DATA_W-1:0]        prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     enable;
    logic signed [DATA_W-1:0] input_1;
    logic signed [DATA_W-1:0] input_2;
    logic signed [DATA_W-1:0] final_output;
    logic                     total_ovf;
    logic                     total_zero;
    logic [2:0]               ovf_stage;
    logic [2:0]               zero_stage;
    logic                     busy;

    logic [DATA_W-1:0] shadow [PARAM_NUM];  // Parameter values the DUT should hold
    logic [15:0]       lfsr_state;
    int                checks;
    int                fails;
    int                timeouts;

    nn_top dut0 (
        .clk(clk), .resetn(resetn),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .enable(enable), .input_1(input_1), .input_2(input_2),
        .final_output(final_output),
        .total_ovf(total_ovf), .total_zero(total_zero),
        .ovf_stage(ovf_stage), .zero_stage(zero_stage),
        .busy(busy)
    );

    always #5 clk = ~clk;               // 10 ns period

    // Galois LFSR, one step per bit taken
    function automatic logic [DATA_W-1:0] lfsr_bits(input int n);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[DATA_W-2:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            fails++;
            $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Range test on a 64-bit value
    function automatic logic fits_word(input logic signed [63:0] v);
        return (v >= -64'sd2147483648) && (v <= 64'sd2147483647);
    endfunction

    function automatic void mac_ref(input logic signed [DATA_W-1:0] a, b, c,
                                    output logic signed [DATA_W-1:0] res,
                                    output logic o, z);
        logic signed [63:0]       p;
        logic signed [DATA_W-1:0] lo;
        logic signed [63:0]       s;
        p   = 64'(a) * 64'(b);          // Exact product
        lo  = p[DATA_W-1:0];
        s   = 64'(lo) + 64'(c);         // Exact sum
        res = s[DATA_W-1:0];
        o   = !fits_word(p) || !fits_word(s);
        z   = (lo == '0) || (res == '0);
    endfunction

    // First raise of a flag names its stage
    function automatic void flag_stage(input logic [2:0] stage, input logic o, z,
                                       inout logic ovf, zero,
                                       inout logic [2:0] ovf_st, zero_st);
        if (z && !zero) zero_st = stage;
        if (o && !ovf) ovf_st = stage;
        zero = zero | z;
        ovf  = ovf | o;
    endfunction

    function automatic void model(input logic signed [DATA_W-1:0] in1, in2,
                                  output logic signed [DATA_W-1:0] out,
                                  output logic ovf, zero,
                                  output logic [2:0] ovf_st, zero_st);
        logic signed [DATA_W-1:0] i1, i2, i3, i4, t, i5;
        logic signed [63:0]       wide;
        logic                     o_a, o_b, z_a, z_b;
        ovf     = 1'b0;
        zero    = 1'b0;
        ovf_st  = STAGE_NONE;
        zero_st = STAGE_NONE;
        out     = SAT_POS;              // Kept when a stage overflows
        i1 = in1 >>> shadow[PI_SHIFT1][SHAMT_W-1:0];
        i2 = in2 >>> shadow[PI_SHIFT2][SHAMT_W-1:0];
        flag_stage(ST_PRE, 1'b0, (i1 == '0) || (i2 == '0), ovf, zero, ovf_st, zero_st);
        mac_ref(i1, shadow[PI_W1], shadow[PI_B1], i3, o_a, z_a);
        mac_ref(i2, shadow[PI_W2], shadow[PI_B2], i4, o_b, z_b);
        flag_stage(ST_IN, o_a | o_b, z_a | z_b, ovf, zero, ovf_st, zero_st);
        if (ovf) return;
        mac_ref(i3, shadow[PI_W3], shadow[PI_B3], t, o_a, z_a);
        flag_stage(ST_OUT, o_a, z_a, ovf, zero, ovf_st, zero_st);
        if (ovf) return;
        mac_ref(i4, shadow[PI_W4], t, i5, o_a, z_a);  // Chained on the first MAC
        flag_stage(ST_OUT, o_a, z_a, ovf, zero, ovf_st, zero_st);
        if (ovf) return;
        wide = 64'(i5) <<< shadow[PI_SHIFT3][SHAMT_W-1:0];
        flag_stage(ST_POST, !fits_word(wide), wide[DATA_W-1:0] == '0,
                   ovf, zero, ovf_st, zero_st);
        if (!ovf) out = wide[DATA_W-1:0];
    endfunction

    // Sample just after the falling edge, waiting out back-pressure
    task automatic wait_pready(output logic ok, output int stalls);
        stalls = 0;
        #1;
        while (!pready && stalls < APB_TIMEOUT) begin
            @(negedge clk);
            #1;
            stalls++;
        end
        ok = pready;
    endtask

    task automatic apb_write(input logic [PADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             output logic err, output int stalls);
        logic ok;
        @(negedge clk);
        psel    = 1'b1;                 // Setup phase
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;                 // Access phase
        wait_pready(ok, stalls);
        err = pslverr;
        if (!ok) begin
            timeouts++;
            $display("APB write to address %0d never saw pready", addr);
        end else if (int'(addr) < PARAM_NUM) begin
            shadow[addr] = data;
        end
        @(posedge clk);                 // Completing edge
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [PADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic err);
        logic ok;
        int   stalls;
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        wait_pready(ok, stalls);
        data = prdata;
        err  = pslverr;
        if (!ok) begin
            timeouts++;
            $display("APB read of address %0d never saw pready", addr);
        end
        @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_param(input logic [PADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic err;
        int   stalls;
        apb_write(addr, data, err, stalls);
        check_val("pslverr", DATA_W'(err), '0);
    endtask

    // Small positive values, no zero and no overflow anywhere
    task automatic load_small_params();
        write_param(PI_SHIFT1, lfsr_bits(2));
        write_param(PI_SHIFT2, lfsr_bits(2));
        write_param(PI_SHIFT3, lfsr_bits(2));
        write_param(PI_W1, lfsr_bits(4) + 32'd1);
        write_param(PI_B1, lfsr_bits(8));
        write_param(PI_W2, lfsr_bits(4) + 32'd1);
        write_param(PI_B2, lfsr_bits(8));
        write_param(PI_W3, lfsr_bits(4) + 32'd1);
        write_param(PI_W4, lfsr_bits(4) + 32'd1);
        write_param(PI_B3, lfsr_bits(8));
    endtask

    task automatic run_net(input logic signed [DATA_W-1:0] in1, in2);
        logic signed [DATA_W-1:0] exp_out;
        logic                     exp_ovf;
        logic                     exp_zero;
        logic [2:0]               exp_ovf_st;
        logic [2:0]               exp_zero_st;
        int                       cycles;
        model(in1, in2, exp_out, exp_ovf, exp_zero, exp_ovf_st, exp_zero_st);
        @(negedge clk);
        input_1 = in1;
        input_2 = in2;
        enable  = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        if (!busy) begin
            fails++;
            $display("Run did not start, busy stayed low after enable");
        end
        cycles = 0;
        while (busy && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            timeouts++;
            $display("Run never finished, busy still high after %0d cycles", cycles);
        end else begin
            check_val("final_output", final_output, exp_out);
            check_val("total_ovf", DATA_W'(total_ovf), DATA_W'(exp_ovf));
            check_val("total_zero", DATA_W'(total_zero), DATA_W'(exp_zero));
            check_val("ovf_stage", DATA_W'(ovf_stage), DATA_W'(exp_ovf_st));
            check_val("zero_stage", DATA_W'(zero_stage), DATA_W'(exp_zero_st));
        end
    endtask

    task automatic reset_state();
        logic [DATA_W-1:0] rd;
        logic              err;
        check_val("busy", DATA_W'(busy), '0);
        check_val("pready", DATA_W'(pready), 32'd1);
        check_val("pslverr", DATA_W'(pslverr), '0);
        check_val("total_ovf", DATA_W'(total_ovf), '0);
        check_val("total_zero", DATA_W'(total_zero), '0);
        check_val("ovf_stage", DATA_W'(ovf_stage), DATA_W'(STAGE_NONE));
        check_val("zero_stage", DATA_W'(zero_stage), DATA_W'(STAGE_NONE));
        check_val("final_output", final_output, '0);
        for (int a = 0; a < PARAM_NUM; a++) begin
            apb_read(PADDR_W'(a), rd, err);
            check_val("prdata", rd, '0);
        end
    endtask

    task automatic apb_readback();
        logic [DATA_W-1:0] rd;
        logic              err;
        int                stalls;
        for (int a = 0; a < PARAM_NUM; a++) begin
            write_param(PADDR_W'(a), lfsr_bits(32));
        end
        for (int a = PARAM_NUM; a < (1 << PADDR_W); a++) begin
            apb_write(PADDR_W'(a), lfsr_bits(32), err, stalls);
            check_val("pslverr", DATA_W'(err), 32'd1);
            apb_read(PADDR_W'(a), rd, err);
            check_val("pslverr", DATA_W'(err), 32'd1);
            check_val("prdata", rd, '0);
        end
        for (int a = 0; a < PARAM_NUM; a++) begin
            apb_read(PADDR_W'(a), rd, err);  // Also proves bad writes changed nothing
            check_val("prdata", rd, shadow[a]);
            check_val("pslverr", DATA_W'(err), '0);
        end
    endtask

    task automatic normal_inference();
        for (int n = 0; n < 8; n++) begin
            load_small_params();
            run_net($signed(lfsr_bits(10) + 32'd16), $signed(lfsr_bits(10) + 32'd16));
            check_val("total_ovf", DATA_W'(total_ovf), '0);
            check_val("total_zero", DATA_W'(total_zero), '0);
        end
    endtask

    task automatic overflow_saturation();
        write_param(PI_SHIFT1, 32'd0);
        write_param(PI_W1, 32'h4000_0000);  // Product far beyond 32 bits
        run_net(32'sh1000_0000, 32'sd100);
        check_val("final_output", final_output, SAT_POS);
        check_val("total_ovf", DATA_W'(total_ovf), 32'd1);
        check_val("ovf_stage", DATA_W'(ovf_stage), 32'd4);  // Input layer
        load_small_params();
    endtask

    task automatic zero_flag_tracking();
        write_param(PI_SHIFT1, 32'd31);     // inter_1 shifts to zero
        write_param(PI_W3, 32'd0);          // Output layer zero as well
        run_net(32'sd100, 32'sd200);
        check_val("total_zero", DATA_W'(total_zero), 32'd1);
        check_val("zero_stage", DATA_W'(zero_stage), 32'd3);
        write_param(PI_SHIFT1, 32'd1);
        write_param(PI_W3, 32'd5);
        run_net(32'sd100, 32'sd200);        // Clean run clears both
        check_val("total_zero", DATA_W'(total_zero), '0);
        check_val("zero_stage", DATA_W'(zero_stage), DATA_W'(STAGE_NONE));
    endtask

    task automatic write_during_run();
        logic signed [DATA_W-1:0] in1;
        logic signed [DATA_W-1:0] in2;
        logic [DATA_W-1:0]        new_w1;
        logic [DATA_W-1:0]        rd;
        logic                     err;
        int                       stalls;
        in1    = $signed(lfsr_bits(10) + 32'd16);
        in2    = $signed(lfsr_bits(10) + 32'd16);
        new_w1 = shadow[PI_W1] + 32'd3;
        fork
            run_net(in1, in2);                      // Expects the old w1
            apb_write(PI_W1, new_w1, err, stalls);  // Access phase while busy
        join
        check_val("pslverr", DATA_W'(err), '0);
        assert (stalls > 0) else begin
            fails++;
            $display("APB write during a run was not held off");
        end
        apb_read(PI_W1, rd, err);
        check_val("prdata", rd, new_w1);
        run_net(in1, in2);                  // New w1 now in use
    endtask

    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        enable     = 1'b0;
        input_1    = '0;
        input_2    = '0;
        lfsr_state = 16'd38818;
        checks     = 0;
        fails      = 0;
        timeouts   = 0;
        for (int a = 0; a < PARAM_NUM; a++) begin
            shadow[a] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        reset_state();
        apb_readback();
        normal_inference();
        overflow_saturation();
        zero_flag_tracking();
        write_during_run();
        @(negedge clk);
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, fails, timeouts);
        if (fails == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- nn.f
nn_pkg.sv
nn_alu.sv
nn_mac.sv
nn_param_regs.sv
nn_seq.sv
nn_top.sv
tb_nn.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_nn -f nn.f -o sim_nn
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_nn > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
